// File: hw/bank_config.svh
`ifndef BANK_CONFIG_SVH
`define BANK_CONFIG_SVH

// data path widths
`define BANK_SAMPLE_BITS 8
`define BANK_WORD_BITS 16

// 256 words, split into two banks of 128
`define BANK_ADDR_BITS 8

// host bus
`define BANK_AXIL_ADDR_BITS 4

// register map, byte offsets
`define BANK_REG_DATA 4'h0
`define BANK_REG_STATUS 4'h4
`define BANK_REG_CLEAR 4'h8

`endif

// File: hw/fifo_pkg.sv
`default_nettype none

`include "bank_config.svh"

package fifo_pkg;

    // one sample from the source
    typedef logic [`BANK_SAMPLE_BITS-1:0] sample_t;

    // packed pair, first sample in the low byte
    typedef logic [`BANK_WORD_BITS-1:0] word_t;

    // saturating count of words lost on a full FIFO
    typedef logic [15:0] drop_count_t;

    // words taken by the host
    typedef logic [15:0] pop_count_t;

endpackage

`default_nettype wire

// File: hw/axil_pkg.sv
`default_nettype none

`include "bank_config.svh"

package axil_pkg;

    typedef logic [`BANK_AXIL_ADDR_BITS-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    // response codes
    localparam axil_resp_t resp_okay = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    // read channel FSM
    typedef enum logic {
        rd_idle,
        rd_resp
    } rd_state_t;

endpackage

`default_nettype wire

// File: hw/sample_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sample_capture
    import fifo_pkg::*;
(
    input  wire logic    w_clk,
    input  wire logic    rst,
    input  wire logic    sample_valid,
    input  wire sample_t sample_data,
    input  wire logic    fifo_ok,
    output logic         push,
    output word_t        push_data,
    output drop_count_t  drop_count
);

    logic [1:0] rst_sync;
    logic       w_rst;
    logic       have_low;
    sample_t    low_sample;

    // bring rst over from r_clk
    always_ff @(posedge w_clk) begin
        rst_sync <= {rst_sync[0], rst};
    end

    assign w_rst = rst_sync[1];

    // first sample of a pair waits here
    always_ff @(posedge w_clk) begin
        if (sample_valid && !have_low) begin
            low_sample <= sample_data;
        end
    end

    always_ff @(posedge w_clk) begin
        if (sample_valid && have_low) begin
            push_data <= {sample_data, low_sample};
        end
    end

    // pair tracking, push strobe and drop counter
    always_ff @(posedge w_clk) begin
        if (w_rst) begin
            have_low   <= 1'b0;
            push       <= 1'b0;
            drop_count <= '0;
        end else begin
            push <= 1'b0;
            if (sample_valid) begin
                have_low <= !have_low;
                if (have_low) begin
                    if (fifo_ok) begin
                        push <= 1'b1;
                    end else if (drop_count != '1) begin
                        drop_count <= drop_count + 1'b1;
                    end
                end
            end
        end
    end

    // FIFO room only shrinks through our own pushes, so the
    // registered decision must still hold on the push cycle
    push_has_room: assert property (
        @(posedge w_clk) disable iff (w_rst)
        push |-> fifo_ok
    ) else $error("push raised while the FIFO reports no room");

endmodule

`default_nettype wire

// File: hw/bank_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "bank_config.svh"

module bank_fifo
    import fifo_pkg::*;
#(
    // two banks need at least one bit below the bank select
    parameter int addr_bits = `BANK_ADDR_BITS
) (
    input  wire logic  w_clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire word_t push_data,
    output logic       w_ok,
    input  wire logic  r_clk,
    input  wire logic  pop,
    output word_t      pop_data,
    output logic       r_ok
);

    localparam int depth = 1 << addr_bits;

    typedef logic [addr_bits-1:0] addr_t;

    word_t mem [depth];

    // ======================================================================
    // write domain
    // ======================================================================
    logic [1:0] w_rst_sync;
    logic       w_rst;
    addr_t      w_addr;
    logic [1:0] w_bits;
    logic [1:0] w_rbits_meta;
    logic [1:0] w_rbits;

    always_ff @(posedge w_clk) begin
        w_rst_sync <= {w_rst_sync[0], rst};
    end

    assign w_rst = w_rst_sync[1];

    // room while some bank is not yet handed to the reader
    assign w_ok = (w_bits[0] == w_rbits[0]) || (w_bits[1] == w_rbits[1]);

    always_ff @(posedge w_clk) begin
        if (push) begin
            mem[w_addr] <= push_data;
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_rst) begin
            w_addr <= '0;
        end else if (push) begin
            w_addr <= w_addr + 1'b1;
        end
    end

    // ======================================================================
    // read domain
    // ======================================================================
    addr_t      r_addr;
    logic [1:0] r_bits;
    logic [1:0] r_wbits_meta;
    logic [1:0] r_wbits;

    assign pop_data = mem[r_addr];
    assign r_ok = (r_bits[0] != r_wbits[0]) || (r_bits[1] != r_wbits[1]);

    always_ff @(posedge r_clk) begin
        if (rst) begin
            r_addr <= '0;
        end else if (pop) begin
            r_addr <= r_addr + 1'b1;
        end
    end

    // ======================================================================
    // bank toggles, flipped on leaving the last word of a bank
    // ======================================================================
    always_ff @(posedge w_clk) begin
        if (w_rst) begin
            w_bits <= '0;
        end else if (push && (&w_addr[addr_bits-2:0])) begin
            w_bits[w_addr[addr_bits-1]] <= !w_bits[w_addr[addr_bits-1]];
        end
    end

    always_ff @(posedge r_clk) begin
        if (rst) begin
            r_bits <= '0;
        end else if (pop && (&r_addr[addr_bits-2:0])) begin
            r_bits[r_addr[addr_bits-1]] <= !r_bits[r_addr[addr_bits-1]];
        end
    end

    // ======================================================================
    // toggle synchronizers, two flops per direction
    // ======================================================================
    always_ff @(posedge r_clk) begin
        if (rst) begin
            {r_wbits, r_wbits_meta} <= '0;
        end else begin
            {r_wbits, r_wbits_meta} <= {r_wbits_meta, w_bits};
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_rst) begin
            {w_rbits, w_rbits_meta} <= '0;
        end else begin
            {w_rbits, w_rbits_meta} <= {w_rbits_meta, r_bits};
        end
    end

    pop_needs_data: assert property (
        @(posedge r_clk) disable iff (rst)
        pop |-> r_ok
    ) else $error("pop issued with no readable bank");

endmodule

`default_nettype wire

// File: hw/axil_read_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "bank_config.svh"

module axil_read_port
    import fifo_pkg::*;
    import axil_pkg::*;
(
    input  wire logic       r_clk,
    input  wire logic       rst,

    // read address and data
    input  wire logic       arvalid,
    output logic            arready,
    input  wire axil_addr_t araddr,
    output logic            rvalid,
    input  wire logic       rready,
    output axil_data_t      rdata,
    output axil_resp_t      rresp,

    // write address, data and response
    input  wire logic       awvalid,
    output logic            awready,
    input  wire axil_addr_t awaddr,
    input  wire logic       wvalid,
    output logic            wready,
    input  wire axil_data_t wdata,
    input  wire axil_strb_t wstrb,
    output logic            bvalid,
    input  wire logic       bready,
    output axil_resp_t      bresp,

    // FIFO read side
    input  wire logic       fifo_ok,
    input  wire word_t      fifo_data,
    output logic            pop,
    output pop_count_t      pop_count
);

    rd_state_t rd_state;
    logic      rd_accept;
    logic      wr_accept;
    logic      wr_clear;

    // ======================================================================
    // read channel
    // ======================================================================
    assign arready   = (rd_state == rd_idle);
    assign rvalid    = (rd_state == rd_resp);
    assign rd_accept = arvalid && arready;

    // pop on the acceptance cycle, only with data waiting
    assign pop = rd_accept && (araddr == `BANK_REG_DATA) && fifo_ok;

    always_ff @(posedge r_clk) begin
        if (rst) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: begin
                    if (arvalid) begin
                        rd_state <= rd_resp;
                    end
                end
                rd_resp: begin
                    if (rready) begin
                        rd_state <= rd_idle;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // response latched at acceptance, held until taken
    always_ff @(posedge r_clk) begin
        if (rd_accept) begin
            case (araddr)
                `BANK_REG_DATA: begin
                    if (fifo_ok) begin
                        rdata <= axil_data_t'(fifo_data);
                        rresp <= resp_okay;
                    end else begin
                        rdata <= '0;
                        rresp <= resp_slverr;
                    end
                end
                `BANK_REG_STATUS: begin
                    rdata <= {pop_count, 15'd0, fifo_ok};
                    rresp <= resp_okay;
                end
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;
                end
            endcase
        end
    end

    // ======================================================================
    // write channel, one response outstanding at most
    // ======================================================================
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // write 1 to bit 0 of CLEAR to zero the pop count
    assign wr_clear = wr_accept && (awaddr == `BANK_REG_CLEAR) && wstrb[0] && wdata[0];

    always_ff @(posedge r_clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge r_clk) begin
        if (wr_accept) begin
            bresp <= (awaddr == `BANK_REG_CLEAR) ? resp_okay : resp_slverr;
        end
    end

    // pop counter, a same-cycle pop survives the clear
    always_ff @(posedge r_clk) begin
        if (rst) begin
            pop_count <= '0;
        end else if (wr_clear || pop) begin
            pop_count <= (wr_clear ? '0 : pop_count) + pop_count_t'(pop);
        end
    end

    rdata_held: assert property (
        @(posedge r_clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else $error("read response changed while stalled");

    bresp_held: assert property (
        @(posedge r_clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else $error("write response changed while stalled");

endmodule

`default_nettype wire

// File: hw/capture_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_bridge_top
    import fifo_pkg::*;
    import axil_pkg::*;
(
    input  wire logic       w_clk,
    input  wire logic       r_clk,
    input  wire logic       rst,

    // sample source, w_clk domain
    input  wire logic       sample_valid,
    input  wire sample_t    sample_data,
    output drop_count_t     drop_count,

    // host bus, r_clk domain
    input  wire logic       arvalid,
    output logic            arready,
    input  wire axil_addr_t araddr,
    output logic            rvalid,
    input  wire logic       rready,
    output axil_data_t      rdata,
    output axil_resp_t      rresp,
    input  wire logic       awvalid,
    output logic            awready,
    input  wire axil_addr_t awaddr,
    input  wire logic       wvalid,
    output logic            wready,
    input  wire axil_data_t wdata,
    input  wire axil_strb_t wstrb,
    output logic            bvalid,
    input  wire logic       bready,
    output axil_resp_t      bresp
);

    logic  push;
    word_t push_data;
    logic  w_ok;
    logic  pop;
    word_t pop_data;
    logic  r_ok;

    sample_capture u_capture (
        .w_clk, .rst, .sample_valid, .sample_data,
        .fifo_ok (w_ok),
        .push, .push_data, .drop_count
    );

    bank_fifo u_fifo (
        .w_clk, .rst, .push, .push_data, .w_ok,
        .r_clk, .pop, .pop_data, .r_ok
    );

    // pop count only visible through STATUS
    axil_read_port u_host (
        .r_clk, .rst,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .fifo_ok   (r_ok),
        .fifo_data (pop_data),
        .pop,
        .pop_count ()
    );

endmodule

`default_nettype wire

// File: verif/tb_capture_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bank_config.svh"

module tb_capture_bridge
    import fifo_pkg::*;
    import axil_pkg::*;
();

    localparam int stream_samples   = 600;
    localparam int overflow_samples = 1200;
    localparam int stall_samples    = 256;
    localparam int bank_words       = 1 << (`BANK_ADDR_BITS - 1);
    // budget per sample plus setup and drain time
    localparam int cycle_limit =
        20 * (stream_samples + overflow_samples + stall_samples) + 5000;

    logic        w_clk;
    logic        r_clk;
    logic        rst;
    logic        sample_valid;
    sample_t     sample_data;
    drop_count_t drop_count;
    logic        arvalid;
    logic        arready;
    axil_addr_t  araddr;
    logic        rvalid;
    logic        rready;
    axil_data_t  rdata;
    axil_resp_t  rresp;
    logic        awvalid;
    logic        awready;
    axil_addr_t  awaddr;
    logic        wvalid;
    logic        wready;
    axil_data_t  wdata;
    axil_strb_t  wstrb;
    logic        bvalid;
    logic        bready;
    axil_resp_t  bresp;

    // expected words, oldest first
    word_t   exp_q[$];
    int      pops_ok;
    logic    pair_open;
    sample_t low_byte;
    logic    src_done;
    int      cycle_count = 0;

    capture_bridge_top dut (
        .w_clk, .r_clk, .rst, .sample_valid, .sample_data, .drop_count,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp
    );

    initial begin
        r_clk = 1'b0;
        forever #5 r_clk = ~r_clk;
    end

    initial begin
        w_clk = 1'b0;
        forever #7 w_clk = ~w_clk;
    end

    always @(posedge r_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d r_clk cycles, the run did not finish", cycle_count);
            $display("** FAIL **");
            $fatal(1, "simulation timed out");
        end
    end

    // ======================================================================
    // reference model and compare tasks
    // ======================================================================
    // first sample of a pair goes to the low byte
    function automatic word_t pack_pair(input sample_t first, input sample_t second);
        return {second, first};
    endfunction

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        stop_on_error();
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic verify_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic drops_equal(input string name, input drop_count_t exp,
                               input drop_count_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic pops_equal(input string name, input pop_count_t exp, input pop_count_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    // ======================================================================
    // sample source and AXI4-Lite host
    // ======================================================================
    task automatic send_samples(input int count, input int max_gap);
        sample_t s;
        int      gap;
        int      i;
        int      g;
        for (i = 0; i < count; i++) begin
            s = sample_t'($urandom);
            gap = $urandom_range(max_gap, 0);
            @(negedge w_clk);
            sample_valid = 1'b1;
            sample_data  = s;
            if (pair_open) begin
                exp_q.push_back(pack_pair(low_byte, s));
            end else begin
                low_byte = s;
            end
            pair_open = !pair_open;
            for (g = 0; g < gap; g++) begin
                @(negedge w_clk);
                sample_valid = 1'b0;
            end
        end
        @(negedge w_clk);
        sample_valid = 1'b0;
    endtask

    task automatic sample_drops(output drop_count_t d);
        @(negedge w_clk);
        d = drop_count;
    endtask

    // rready stays low for a random number of cycles once rvalid is up
    task automatic host_read(input axil_addr_t addr, input int max_stall,
                             output axil_data_t data, output axil_resp_t resp);
        int stall;
        int i;
        stall = $urandom_range(max_stall, 0);
        @(negedge r_clk);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge r_clk);
        @(negedge r_clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge r_clk);
        data = rdata;
        resp = rresp;
        for (i = 0; i < stall; i++) begin
            @(negedge r_clk);
            if (!rvalid || rdata !== data || rresp !== resp) begin
                report_failure("read response changed while rready was held low");
            end
        end
        rready = 1'b1;
        @(negedge r_clk);
        rready = 0;
    endtask

    // address first, data one cycle later, response one cycle after acceptance
    task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                             output axil_resp_t resp);
        @(negedge r_clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        @(negedge r_clk);
        if (awready || wready) begin
            report_failure("write channel ready with only the address valid");
        end
        wvalid = 1'b1;
        @(negedge r_clk);
        if (!bvalid) begin
            report_failure("bvalid did not follow the accepted write by one cycle");
        end
        if (awready || wready) begin
            report_failure("write channel ready while a response was pending");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        bready  = 1'b1;
        @(negedge r_clk);
        bready  = 1'b0;
    endtask

    // read DATA until the FIFO answers empty
    task automatic drain_fifo(input string name, input int max_stall, output int count);
        axil_data_t data;
        axil_resp_t resp;
        logic       more;
        count = 0;
        more  = 1'b1;
        while (more) begin
            host_read(`BANK_REG_DATA, max_stall, data, resp);
            if (resp !== resp_okay) begin
                verify_resp({name, " empty resp"}, resp_slverr, resp);
                compare_word({name, " empty data"}, '0, data[15:0]);
                more = 1'b0;
            end else if (exp_q.size() == 0) begin
                report_failure({name, ": FIFO returned a word that was never sent"});
            end else begin
                compare_word(name, exp_q.pop_front(), data[15:0]);
                compare_word({name, " upper half"}, '0, data[31:16]);
                count++;
                pops_ok++;
            end
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        axil_data_t  data;
        axil_resp_t  resp;
        drop_count_t drops;
        drop_count_t overflow_drops;
        int          n;
        int          n_before;
        int          quiet;

        void'($urandom(32'h20e6_7ae9));
        rst = 1'b1;
        sample_valid = 1'b0;
        sample_data = '0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        pops_ok = 0;
        pair_open = 1'b0;
        low_byte = '0;
        src_done = 1'b0;

        repeat (16) @(negedge r_clk);
        rst = 1'b0;
        // w_clk side leaves reset a few cycles later
        repeat (10) @(negedge r_clk);

        // empty FIFO right after reset
        host_read(`BANK_REG_DATA, 0, data, resp);
        verify_resp("empty data resp", resp_slverr, resp);
        compare_word("empty data", '0, data[15:0]);
        host_read(`BANK_REG_STATUS, 0, data, resp);
        compare_word("empty status flags", '0, data[15:0]);
        pops_equal("empty status count", '0, data[31:16]);

        // streaming with polling, only whole banks become readable
        quiet = 0;
        fork
            begin
                send_samples(stream_samples, 4);
                src_done = 1'b1;
            end
            while (quiet < 20) begin
                host_read(`BANK_REG_STATUS, 0, data, resp);
                verify_resp("stream status resp", resp_okay, resp);
                if (data[0]) begin
                    drain_fifo("stream word", 0, n);
                    quiet = 0;
                end else if (src_done) begin
                    quiet++;
                end
            end
        join
        sample_drops(drops);
        drops_equal("stream drops", '0, drops);
        if (exp_q.size() >= bank_words) begin
            report_failure("a complete bank was never offered to the host");
        end

        // overflow with no reads, then drain
        n_before = exp_q.size();
        send_samples(overflow_samples, 0);
        repeat (20) @(negedge r_clk);
        drain_fifo("overflow word", 0, n);
        sample_drops(drops);
        drops_equal("overflow total", drop_count_t'(n_before + overflow_samples / 2 - n), drops);
        if (drops == 0) begin
            report_failure("overflow run dropped no words");
        end
        overflow_drops = drops;
        // the dropped words were the tail of the model
        exp_q.delete();

        // pop counter and clear
        host_read(`BANK_REG_STATUS, 0, data, resp);
        pops_equal("pop count", pop_count_t'(pops_ok), data[31:16]);
        write_reg(`BANK_REG_CLEAR, 32'h1, resp);
        verify_resp("clear resp", resp_okay, resp);
        pops_ok = 0;
        host_read(`BANK_REG_STATUS, 0, data, resp);
        pops_equal("pop count after clear", '0, data[31:16]);

        // bad accesses
        write_reg(`BANK_REG_DATA, 32'h1234_5678, resp);
        verify_resp("write to data resp", resp_slverr, resp);
        host_read(4'hc, 0, data, resp);
        verify_resp("read from 0xc resp", resp_slverr, resp);
        compare_word("read from 0xc data", '0, data[15:0]);

        // one full bank read out under back-pressure
        send_samples(stall_samples, 3);
        repeat (20) @(negedge r_clk);
        drain_fifo("stalled word", 6, n);
        if (n != stall_samples / 2 || exp_q.size() != 0) begin
            report_failure("back-pressure run did not read back every word it sent");
        end
        host_read(`BANK_REG_STATUS, 0, data, resp);
        pops_equal("pop count after stalls", pop_count_t'(pops_ok), data[31:16]);
        sample_drops(drops);
        drops_equal("drops after stalls", overflow_drops, drops);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/fifo_pkg.sv
hw/axil_pkg.sv
hw/sample_capture.sv
hw/bank_fifo.sv
hw/axil_read_port.sv
hw/capture_bridge_top.sv
verif/tb_capture_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the capture bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_capture_bridge -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim >> sim.log 2>&1

grep -qF '** PASS **' sim.log \
    && echo "simulation passed, log in sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }
